// File: rtl/sdram_pkg.sv
// SDRAM traffic generator shared definitions
// Command encodings, timing constants, address layout and controller states
`default_nettype none

package sdram_pkg;

    // ----------------------------------------
    // Geometry
    // ----------------------------------------
    localparam int ROW_W  = 13;
    localparam int BANK_W = 2;
    localparam int COL_W  = 9;
    localparam int ADR_W  = ROW_W + BANK_W + COL_W;
    localparam int WB_DW  = 16;

    // Timing in clk_50m cycles
    localparam int T_RP    = 2;
    localparam int T_RCD   = 2;
    localparam int T_RFC   = 7;
    localparam int T_MRD   = 2;
    localparam int CAS_LAT = 2;

    // BL1, sequential, CL2, single-location write
    localparam logic [ROW_W-1:0] MODE_WORD = 13'b000_1_00_010_0_000;

    // Address pin source
    localparam logic [1:0] ADR_ROW     = 2'd0;
    localparam logic [1:0] ADR_COL     = 2'd1;
    localparam logic [1:0] ADR_PRE_ALL = 2'd2;
    localparam logic [1:0] ADR_MODE    = 2'd3;

    // {spare, ras_n, cas_n, we_n}
    typedef enum logic [3:0] {
        CMD_LOAD_MODE = 4'b0000,
        CMD_REFRESH   = 4'b0001,
        CMD_PRECHARGE = 4'b0010,
        CMD_ACTIVE    = 4'b0011,
        CMD_WRITE     = 4'b0100,
        CMD_READ      = 4'b0101,
        CMD_NOP       = 4'b0111
    } sdram_cmd_e;

    typedef enum logic [3:0] {
        INIT_WAIT,
        INIT_PRE,
        INIT_REF,
        INIT_MODE,
        IDLE,
        REFRESH,
        ACTIVATE,
        RCD_WAIT,
        RW,
        CAS_WAIT,
        PRE_WAIT
    } ctrl_state_e;

    // ----------------------------------------
    // Word address, flat or split for the pins
    // ----------------------------------------
    typedef struct packed {
        logic [ROW_W-1:0]  row;
        logic [BANK_W-1:0] bank;
        logic [COL_W-1:0]  col;
    } sdram_adr_fields_t;

    typedef union packed {
        logic [ADR_W-1:0]  flat;
        sdram_adr_fields_t fields;
    } sdram_adr_u;

endpackage

`default_nettype wire

// File: rtl/sdram_timer.sv
// SDRAM controller timer
// Reloadable delay counter for init and command spacing, plus the
// free-running auto-refresh interval counter
`timescale 1ns/1ps
`default_nettype none

module sdram_timer #(
    parameter int INIT_CYCLES    = 10000,
    parameter int REFRESH_CYCLES = 390
) (
    input  logic        clk_50m,
    input  logic        arst_n,
    input  logic        timer_load,
    input  logic [15:0] timer_value,
    output logic        timer_done,
    input  logic        refresh_ack,
    output logic        refresh_due
);

    localparam logic [15:0] REF_RELOAD = 16'(REFRESH_CYCLES - 1);
    // First interval also covers the power-up wait
    localparam logic [15:0] REF_FIRST  = 16'(INIT_CYCLES + REFRESH_CYCLES - 1);

    logic [15:0] wait_cnt;
    logic [15:0] ref_cnt;

    // ----------------------------------------
    // Command delay
    // ----------------------------------------
    // Loaded value is the spacing from the loading command to the next one,
    // so done rises in the last wait cycle
    always_ff @(posedge clk_50m or negedge arst_n) begin
        if (!arst_n) begin
            wait_cnt <= '0;
        end else if (timer_load) begin
            wait_cnt <= timer_value - 16'd1;
        end else if (wait_cnt != '0) begin
            wait_cnt <= wait_cnt - 16'd1;
        end
    end

    assign timer_done = (wait_cnt[15:1] == '0);

    // ----------------------------------------
    // Refresh interval
    // ----------------------------------------
    always_ff @(posedge clk_50m or negedge arst_n) begin
        if (!arst_n) begin
            ref_cnt <= REF_FIRST;
        end else if (ref_cnt == '0) begin
            ref_cnt <= REF_RELOAD;
        end else begin
            ref_cnt <= ref_cnt - 16'd1;
        end
    end

    // Sticky until the FSM issues the refresh
    always_ff @(posedge clk_50m or negedge arst_n) begin
        if (!arst_n) begin
            refresh_due <= 1'b0;
        end else if (ref_cnt == '0) begin
            refresh_due <= 1'b1;
        end else if (refresh_ack) begin
            refresh_due <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: rtl/sdram_cmd_fsm.sv
// SDRAM controller state machine
// Runs the power-up sequence, auto-refresh and single-word accesses,
// and acts as the Wishbone classic slave
`timescale 1ns/1ps
`default_nettype none

module sdram_cmd_fsm
    import sdram_pkg::*;
#(
    parameter int INIT_CYCLES = 10000
) (
    input  logic        clk_50m,
    input  logic        arst_n,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    output logic        wb_ack,
    output logic        timer_load,
    output logic [15:0] timer_value,
    input  logic        timer_done,
    input  logic        refresh_due,
    output logic        refresh_ack,
    output sdram_cmd_e  cmd,
    output logic [1:0]  adr_sel,
    output logic        dq_oe,
    output logic        capture
);

    ctrl_state_e state;
    ctrl_state_e state_nxt;

    // High in the first cycle of a state, when its command goes out
    logic issue;
    logic reissue;
    // Second of the two init refreshes
    logic ref_second;

    always_ff @(posedge clk_50m or negedge arst_n) begin
        if (!arst_n) begin
            state      <= INIT_WAIT;
            issue      <= 1'b1;
            ref_second <= 1'b0;
        end else begin
            state <= state_nxt;
            issue <= (state_nxt != state) || reissue;
            if (reissue) begin
                ref_second <= 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Next state and outputs
    // ----------------------------------------
    always_comb begin
        state_nxt   = state;
        reissue     = 1'b0;
        cmd         = CMD_NOP;
        adr_sel     = ADR_ROW;
        dq_oe       = 1'b0;
        capture     = 1'b0;
        timer_load  = 1'b0;
        timer_value = '0;
        refresh_ack = 1'b0;
        wb_ack      = 1'b0;

        unique case (state)
            INIT_WAIT: begin
                if (issue) begin
                    timer_load  = 1'b1;
                    timer_value = 16'(INIT_CYCLES);
                end else if (timer_done) begin
                    state_nxt = INIT_PRE;
                end
            end
            INIT_PRE: begin
                if (issue) begin
                    cmd         = CMD_PRECHARGE;
                    adr_sel     = ADR_PRE_ALL;
                    timer_load  = 1'b1;
                    timer_value = 16'(T_RP);
                end else if (timer_done) begin
                    state_nxt = INIT_REF;
                end
            end
            INIT_REF: begin
                if (issue) begin
                    cmd         = CMD_REFRESH;
                    refresh_ack = 1'b1;
                    timer_load  = 1'b1;
                    timer_value = 16'(T_RFC);
                end else if (timer_done) begin
                    if (ref_second) begin
                        state_nxt = INIT_MODE;
                    end else begin
                        reissue = 1'b1;
                    end
                end
            end
            INIT_MODE: begin
                if (issue) begin
                    cmd         = CMD_LOAD_MODE;
                    adr_sel     = ADR_MODE;
                    timer_load  = 1'b1;
                    timer_value = 16'(T_MRD);
                end else if (timer_done) begin
                    state_nxt = IDLE;
                end
            end
            IDLE: begin
                // Refresh wins over a waiting request
                if (refresh_due) begin
                    state_nxt = REFRESH;
                end else if (wb_cyc && wb_stb) begin
                    state_nxt = ACTIVATE;
                end
            end
            REFRESH: begin
                if (issue) begin
                    cmd         = CMD_REFRESH;
                    refresh_ack = 1'b1;
                    timer_load  = 1'b1;
                    timer_value = 16'(T_RFC);
                end else if (timer_done) begin
                    state_nxt = IDLE;
                end
            end
            ACTIVATE: begin
                cmd         = CMD_ACTIVE;
                adr_sel     = ADR_ROW;
                timer_load  = 1'b1;
                timer_value = 16'(T_RCD);
                state_nxt   = RCD_WAIT;
            end
            RCD_WAIT: begin
                if (timer_done) begin
                    state_nxt = RW;
                end
            end
            RW: begin
                adr_sel = ADR_COL;
                if (wb_we) begin
                    cmd       = CMD_WRITE;
                    dq_oe     = 1'b1;
                    state_nxt = PRE_WAIT;
                end else begin
                    cmd         = CMD_READ;
                    timer_load  = 1'b1;
                    // One extra cycle for the pin register
                    timer_value = 16'(CAS_LAT + 1);
                    state_nxt   = CAS_WAIT;
                end
            end
            CAS_WAIT: begin
                if (timer_done) begin
                    state_nxt = PRE_WAIT;
                end
            end
            PRE_WAIT: begin
                if (issue) begin
                    cmd         = CMD_PRECHARGE;
                    adr_sel     = ADR_PRE_ALL;
                    capture     = !wb_we;
                    timer_load  = 1'b1;
                    timer_value = 16'(T_RP);
                end else if (timer_done) begin
                    wb_ack    = 1'b1;
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/sdram_datapath.sv
// SDRAM pin datapath
// Registers command and address pins, drives the DQ bus for writes
// and captures read data
`timescale 1ns/1ps
`default_nettype none

module sdram_datapath
    import sdram_pkg::*;
(
    input  logic              clk_50m,
    input  logic              arst_n,
    input  sdram_cmd_e        cmd,
    input  logic [1:0]        adr_sel,
    input  sdram_adr_u        wb_adr,
    input  logic [WB_DW-1:0]  wb_dat_w,
    input  logic              dq_oe,
    input  logic              capture,
    output logic [WB_DW-1:0]  rd_data,
    output logic              sdram_cke,
    output logic              sdram_nras,
    output logic              sdram_ncas,
    output logic              sdram_nwe,
    output logic              sdram_dqml,
    output logic              sdram_dqmh,
    output logic [ROW_W-1:0]  sdram_a,
    output logic [BANK_W-1:0] sdram_ba,
    inout  wire  [WB_DW-1:0]  sdram_dq
);

    // A10 high selects all banks
    localparam logic [ROW_W-1:0] A10_ALL = 13'h0400;

    logic [ROW_W-1:0] a_nxt;
    logic [WB_DW-1:0] wr_q;
    logic             dq_oe_q;

    always_comb begin
        unique case (adr_sel)
            ADR_ROW:     a_nxt = wb_adr.fields.row;
            ADR_COL:     a_nxt = {{(ROW_W - COL_W){1'b0}}, wb_adr.fields.col};
            ADR_PRE_ALL: a_nxt = A10_ALL;
            default:     a_nxt = MODE_WORD;
        endcase
    end

    always_ff @(posedge clk_50m or negedge arst_n) begin
        if (!arst_n) begin
            sdram_cke <= 1'b0;
            // NOP
            {sdram_nras, sdram_ncas, sdram_nwe} <= 3'b111;
            dq_oe_q <= 1'b0;
        end else begin
            sdram_cke <= 1'b1;
            {sdram_nras, sdram_ncas, sdram_nwe} <= cmd[2:0];
            dq_oe_q <= dq_oe;
        end
    end

    always_ff @(posedge clk_50m) begin
        sdram_a  <= a_nxt;
        sdram_ba <= wb_adr.fields.bank;
        wr_q     <= wb_dat_w;
        if (capture) begin
            rd_data <= sdram_dq;
        end
    end

    assign sdram_dq   = dq_oe_q ? wr_q : 'z;
    assign sdram_dqml = 1'b0;
    assign sdram_dqmh = 1'b0;

endmodule

`default_nettype wire

// File: rtl/traffic_gen.sv
// Traffic generator, Wishbone classic master
// Writes an LFSR pattern to a block of words, reads it back and compares
`timescale 1ns/1ps
`default_nettype none

module traffic_gen
    import sdram_pkg::*;
#(
    parameter int          N_WORDS   = 32,
    parameter logic [15:0] LFSR_SEED = 16'hACE1
) (
    input  logic             clk_50m,
    input  logic             arst_n,
    input  logic             start,
    output logic             wb_cyc,
    output logic             wb_stb,
    output logic             wb_we,
    output sdram_adr_u       wb_adr,
    output logic [WB_DW-1:0] wb_dat_w,
    input  logic [WB_DW-1:0] wb_dat_r,
    input  logic             wb_ack,
    output logic             done,
    output logic             error
);

    localparam logic [ADR_W-1:0] LAST_ADR = ADR_W'(N_WORDS - 1);

    logic [15:0] lfsr;
    logic [15:0] lfsr_next;
    logic        busy;
    logic        rd_phase;
    logic        last;

    // Fibonacci, taps 16 14 13 11
    assign lfsr_next = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
    assign last      = (wb_adr.flat == LAST_ADR);
    assign wb_dat_w  = lfsr;

    always_ff @(posedge clk_50m or negedge arst_n) begin
        if (!arst_n) begin
            wb_cyc   <= 1'b0;
            wb_stb   <= 1'b0;
            wb_we    <= 1'b0;
            wb_adr   <= '0;
            lfsr     <= LFSR_SEED;
            busy     <= 1'b0;
            rd_phase <= 1'b0;
            done     <= 1'b0;
            error    <= 1'b0;
        end else begin
            if (start && !busy) begin
                // Presses during a pass fall through here unseen
                busy        <= 1'b1;
                rd_phase    <= 1'b0;
                done        <= 1'b0;
                error       <= 1'b0;
                lfsr        <= LFSR_SEED;
                wb_adr.flat <= '0;
            end else if (wb_ack) begin
                wb_cyc <= 1'b0;
                wb_stb <= 1'b0;
                if (rd_phase && (wb_dat_r != lfsr)) begin
                    error <= 1'b1;
                end
                if (!last) begin
                    lfsr        <= lfsr_next;
                    wb_adr.flat <= wb_adr.flat + 1'b1;
                end else if (!rd_phase) begin
                    // Write block finished, replay the pattern for reads
                    rd_phase    <= 1'b1;
                    lfsr        <= LFSR_SEED;
                    wb_adr.flat <= '0;
                end else begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end else if (busy && !wb_cyc) begin
                // Bus was idle at least one cycle
                wb_cyc <= 1'b1;
                wb_stb <= 1'b1;
                wb_we  <= !rd_phase;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/top_traffic_gen.sv
// SDRAM traffic generator top level
// Push button starts a write/read-back pass, LEDs show done and mismatch
`timescale 1ns/1ps
`default_nettype none

module top_traffic_gen
    import sdram_pkg::*;
#(
    parameter int          INIT_CYCLES    = 10000,
    parameter int          REFRESH_CYCLES = 390,
    parameter int          N_WORDS        = 32,
    parameter logic [15:0] LFSR_SEED      = 16'hACE1
) (
    input  logic              clk_50m,
    input  logic              arst_n,
    input  logic              pb,
    output logic [1:0]        led,
    output logic              sdram_clk,
    output logic              sdram_cke,
    output logic              sdram_nras,
    output logic              sdram_ncas,
    output logic              sdram_nwe,
    output logic              sdram_dqml,
    output logic              sdram_dqmh,
    output logic [ROW_W-1:0]  sdram_a,
    output logic [BANK_W-1:0] sdram_ba,
    inout  wire  [WB_DW-1:0]  sdram_dq
);

    logic             pb_meta;
    logic             pb_sync;
    logic             pb_prev;
    logic             start;

    logic             wb_cyc;
    logic             wb_stb;
    logic             wb_we;
    sdram_adr_u       wb_adr;
    logic [WB_DW-1:0] wb_dat_w;
    logic [WB_DW-1:0] wb_dat_r;
    logic             wb_ack;
    logic             done;
    logic             error;

    logic             timer_load;
    logic [15:0]      timer_value;
    logic             timer_done;
    logic             refresh_due;
    logic             refresh_ack;
    sdram_cmd_e       cmd;
    logic [1:0]       adr_sel;
    logic             dq_oe;
    logic             capture;

    // ----------------------------------------
    // Button sync and falling edge
    // ----------------------------------------
    always_ff @(posedge clk_50m or negedge arst_n) begin
        if (!arst_n) begin
            pb_meta <= 1'b1;
            pb_sync <= 1'b1;
            pb_prev <= 1'b1;
        end else begin
            pb_meta <= pb;
            pb_sync <= pb_meta;
            pb_prev <= pb_sync;
        end
    end

    assign start     = pb_prev & ~pb_sync;
    assign sdram_clk = clk_50m;
    assign led       = {error, done};

    traffic_gen #(
        .N_WORDS   (N_WORDS),
        .LFSR_SEED (LFSR_SEED)
    ) traffic_gen_i (
        .clk_50m  (clk_50m),
        .arst_n   (arst_n),
        .start    (start),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .done     (done),
        .error    (error)
    );

    sdram_cmd_fsm #(
        .INIT_CYCLES (INIT_CYCLES)
    ) sdram_cmd_fsm_i (
        .clk_50m     (clk_50m),
        .arst_n      (arst_n),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_ack      (wb_ack),
        .timer_load  (timer_load),
        .timer_value (timer_value),
        .timer_done  (timer_done),
        .refresh_due (refresh_due),
        .refresh_ack (refresh_ack),
        .cmd         (cmd),
        .adr_sel     (adr_sel),
        .dq_oe       (dq_oe),
        .capture     (capture)
    );

    sdram_timer #(
        .INIT_CYCLES    (INIT_CYCLES),
        .REFRESH_CYCLES (REFRESH_CYCLES)
    ) sdram_timer_i (
        .clk_50m     (clk_50m),
        .arst_n      (arst_n),
        .timer_load  (timer_load),
        .timer_value (timer_value),
        .timer_done  (timer_done),
        .refresh_ack (refresh_ack),
        .refresh_due (refresh_due)
    );

    sdram_datapath sdram_datapath_i (
        .clk_50m    (clk_50m),
        .arst_n     (arst_n),
        .cmd        (cmd),
        .adr_sel    (adr_sel),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .dq_oe      (dq_oe),
        .capture    (capture),
        .rd_data    (wb_dat_r),
        .sdram_cke  (sdram_cke),
        .sdram_nras (sdram_nras),
        .sdram_ncas (sdram_ncas),
        .sdram_nwe  (sdram_nwe),
        .sdram_dqml (sdram_dqml),
        .sdram_dqmh (sdram_dqmh),
        .sdram_a    (sdram_a),
        .sdram_ba   (sdram_ba),
        .sdram_dq   (sdram_dq)
    );

endmodule

`default_nettype wire

// File: test/sdram_model.sv
// Behavioral SDRAM model, 16-bit, CAS latency 2
// Keeps a small word array and tracks refresh spacing,
// with hooks for reading and corrupting stored words
`timescale 1ns/1ps
`default_nettype none

module sdram_model
    import sdram_pkg::*;
#(
    parameter int DEPTH = 1024
) (
    input  logic              clk,
    input  logic              cke,
    input  logic              nras,
    input  logic              ncas,
    input  logic              nwe,
    input  logic [ROW_W-1:0]  a,
    input  logic [BANK_W-1:0] ba,
    inout  wire  [WB_DW-1:0]  dq
);

    // {ras_n, cas_n, we_n} from the SDRAM truth table
    localparam logic [2:0] PIN_NOP     = 3'b111;
    localparam logic [2:0] PIN_ACTIVE  = 3'b011;
    localparam logic [2:0] PIN_READ    = 3'b101;
    localparam logic [2:0] PIN_WRITE   = 3'b100;
    localparam logic [2:0] PIN_REFRESH = 3'b001;

    logic [WB_DW-1:0] mem [DEPTH];
    logic [ROW_W-1:0] open_row [1 << BANK_W];
    logic [1:0]       rd_valid;
    logic [WB_DW-1:0] rd_word0;
    logic [WB_DW-1:0] rd_word1;
    logic [2:0]       pin_cmd;

    int refresh_count;
    int rfc_violations;
    int rfc_left;
    int since_ref;
    int max_ref_gap;
    logic ref_seen;

    assign pin_cmd = {nras, ncas, nwe};
    // Read data sits on the bus for one cycle, CAS_LAT edges after READ
    assign dq = rd_valid[1] ? rd_word1 : 'z;

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = 16'(i * 40503) ^ 16'h5A3C;
        end
        rd_valid       = '0;
        refresh_count  = 0;
        rfc_violations = 0;
        rfc_left       = 0;
        since_ref      = 0;
        max_ref_gap    = 0;
        ref_seen       = 1'b0;
    end

    function automatic int word_index(input logic [BANK_W-1:0] bank,
                                      input logic [COL_W-1:0] col);
        logic [ADR_W-1:0] flat;
        flat = {open_row[bank], bank, col};
        return int'(flat % DEPTH);
    endfunction

    // ----------------------------------------
    // Hooks for the testbench
    // ----------------------------------------
    function automatic logic [WB_DW-1:0] peek_word(input int idx);
        return mem[idx];
    endfunction

    task automatic flip_bit(input int idx, input int bit_pos);
        mem[idx][bit_pos] = ~mem[idx][bit_pos];
    endtask

    always @(posedge clk) begin
        rd_valid <= {rd_valid[0], 1'b0};
        rd_word1 <= rd_word0;
        if (cke) begin
            // Only NOP or REFRESH inside tRFC
            if (rfc_left > 0) begin
                if ((pin_cmd != PIN_NOP) && (pin_cmd != PIN_REFRESH)) begin
                    rfc_violations++;
                end
                rfc_left--;
            end
            if (ref_seen) begin
                since_ref++;
                if (since_ref > max_ref_gap) begin
                    max_ref_gap = since_ref;
                end
            end
            case (pin_cmd)
                PIN_ACTIVE: open_row[ba] = a;
                PIN_WRITE:  mem[word_index(ba, a[COL_W-1:0])] <= dq;
                PIN_READ: begin
                    rd_valid[0] <= 1'b1;
                    rd_word0    <= mem[word_index(ba, a[COL_W-1:0])];
                end
                PIN_REFRESH: begin
                    refresh_count++;
                    ref_seen  = 1'b1;
                    since_ref = 0;
                    rfc_left  = T_RFC - 1;
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: test/tb_top_chk.sv
// Bound checks for the SDRAM controller
// Wishbone handshake rules and SDRAM command legality
`timescale 1ns/1ps
`default_nettype none

module tb_top_chk
    import sdram_pkg::*;
(
    input logic       clk_50m,
    input logic       arst_n,
    input logic       wb_cyc,
    input logic       wb_stb,
    input logic       wb_we,
    input logic       wb_ack,
    input sdram_cmd_e cmd,
    input logic       dq_oe
);

    int   fail_count;
    logic row_open;

    initial begin
        fail_count = 0;
    end

    // Row state as seen by the FSM
    always_ff @(posedge clk_50m or negedge arst_n) begin
        if (!arst_n) begin
            row_open <= 1'b0;
        end else if (cmd == CMD_ACTIVE) begin
            row_open <= 1'b1;
        end else if (cmd == CMD_PRECHARGE) begin
            row_open <= 1'b0;
        end
    end

    // ----------------------------------------
    // Wishbone
    // ----------------------------------------
    stb_held: assert property (@(posedge clk_50m) disable iff (!arst_n)
        (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_we)))
        else begin
            $error("stb or we changed before ack");
            fail_count++;
        end

    ack_in_cycle: assert property (@(posedge clk_50m) disable iff (!arst_n)
        wb_ack |-> (wb_cyc && wb_stb))
        else begin
            $error("ack outside an active cycle");
            fail_count++;
        end

    // ----------------------------------------
    // SDRAM commands
    // ----------------------------------------
    rw_after_active: assert property (@(posedge clk_50m) disable iff (!arst_n)
        ((cmd == CMD_READ) || (cmd == CMD_WRITE)) |-> row_open)
        else begin
            $error("READ or WRITE with no open row");
            fail_count++;
        end

    // Write data only inside a live write transfer to an opened row
    dq_in_write: assert property (@(posedge clk_50m) disable iff (!arst_n)
        dq_oe |-> (wb_cyc && wb_stb && wb_we && row_open))
        else begin
            $error("dq driven outside a write to an open row");
            fail_count++;
        end

endmodule

`default_nettype wire

// File: test/tb_top.sv
// Testbench for the SDRAM traffic generator
// Random button presses over several passes, an LFSR reference model,
// memory, LED and refresh checks against a behavioral SDRAM
`timescale 1ns/1ps
`default_nettype none

module tb_top
    import sdram_pkg::*;
();

    localparam int          INIT_CYCLES    = 50;
    localparam int          REFRESH_CYCLES = 120;
    localparam int          N_WORDS        = 32;
    localparam logic [15:0] LFSR_SEED      = 16'hACE1;
    localparam int          MAX_PASSES     = 6;
    localparam int          PRESS_CYCLES   = 4;
    localparam int          SETTLE_CYCLES  = 20;
    // A refresh can wait behind one access
    localparam int          REF_SLACK      = 16;

    logic clk_50m;
    logic arst_n;
    logic pb;

    logic [1:0]        led;
    logic              sdram_clk;
    logic              sdram_cke;
    logic              sdram_nras;
    logic              sdram_ncas;
    logic              sdram_nwe;
    logic              sdram_dqml;
    logic              sdram_dqmh;
    logic [ROW_W-1:0]  sdram_a;
    logic [BANK_W-1:0] sdram_ba;
    wire  [WB_DW-1:0]  sdram_dq;

    integer seed;
    int     n_passes;
    int     gap_cycles  [MAX_PASSES];
    logic   corrupt     [MAX_PASSES];
    int     bad_word    [MAX_PASSES];
    int     bad_bit     [MAX_PASSES];
    logic   extra_press [MAX_PASSES];
    int     timeout_cycles;
    logic   stim_ready;
    int     done_rises;
    logic   led0_q;

    top_traffic_gen #(
        .INIT_CYCLES    (INIT_CYCLES),
        .REFRESH_CYCLES (REFRESH_CYCLES),
        .N_WORDS        (N_WORDS),
        .LFSR_SEED      (LFSR_SEED)
    ) top_traffic_gen_i (
        .clk_50m    (clk_50m),
        .arst_n     (arst_n),
        .pb         (pb),
        .led        (led),
        .sdram_clk  (sdram_clk),
        .sdram_cke  (sdram_cke),
        .sdram_nras (sdram_nras),
        .sdram_ncas (sdram_ncas),
        .sdram_nwe  (sdram_nwe),
        .sdram_dqml (sdram_dqml),
        .sdram_dqmh (sdram_dqmh),
        .sdram_a    (sdram_a),
        .sdram_ba   (sdram_ba),
        .sdram_dq   (sdram_dq)
    );

    sdram_model sdram_model_i (
        .clk  (sdram_clk),
        .cke  (sdram_cke),
        .nras (sdram_nras),
        .ncas (sdram_ncas),
        .nwe  (sdram_nwe),
        .a    (sdram_a),
        .ba   (sdram_ba),
        .dq   (sdram_dq)
    );

    bind sdram_cmd_fsm tb_top_chk fsm_chk_i (
        .clk_50m (clk_50m),
        .arst_n  (arst_n),
        .wb_cyc  (wb_cyc),
        .wb_stb  (wb_stb),
        .wb_we   (wb_we),
        .wb_ack  (wb_ack),
        .cmd     (cmd),
        .dq_oe   (dq_oe)
    );

    always #2 clk_50m = ~clk_50m;

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] value);
        return {value[14:0], value[15] ^ value[13] ^ value[12] ^ value[10]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Error %s expected 0x%0h got 0x%0h", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    // Called on a falling edge
    task automatic press_button();
        pb = 1'b0;
        repeat (PRESS_CYCLES) @(negedge clk_50m);
        pb = 1'b1;
    endtask

    task automatic wait_led0(input logic level);
        while (led[0] !== level) @(negedge clk_50m);
    endtask

    // ----------------------------------------
    // End of pass checks
    // ----------------------------------------
    task automatic check_pass(input int p, input int refs_before);
        logic [15:0] expected;
        logic [15:0] want;
        expected = LFSR_SEED;
        check_value("led[0]", 1, led[0]);
        check_value("led[1]", corrupt[p], led[1]);
        // Byte masks stay open for every access
        check_value("sdram_dqml", 0, sdram_dqml);
        check_value("sdram_dqmh", 0, sdram_dqmh);
        for (int k = 0; k < N_WORDS; k++) begin
            want = expected;
            if (corrupt[p] && (k == bad_word[p])) begin
                want[bad_bit[p]] = ~want[bad_bit[p]];
            end
            check_value($sformatf("mem[%0d]", k), want, sdram_model_i.peek_word(k));
            expected = lfsr_step(expected);
        end
        check_value("rfc_violations", 0, sdram_model_i.rfc_violations);
        check_value("refresh_in_pass", 1, sdram_model_i.refresh_count > refs_before);
        check_value("refresh_gap_ok", 1,
                    sdram_model_i.max_ref_gap <= REFRESH_CYCLES + REF_SLACK);
    endtask

    always @(posedge clk_50m) begin
        led0_q <= led[0];
        if (led[0] && !led0_q) begin
            done_rises <= done_rises + 1;
        end
    end

    initial begin
        int refs_before;
        clk_50m        = 1'b0;
        arst_n         = 1'b0;
        pb             = 1'b1;
        seed           = 21;
        stim_ready     = 1'b0;
        done_rises     = 0;
        led0_q         = 1'b0;
        timeout_cycles = 0;
        n_passes       = 4 + ($unsigned($random(seed)) % 3);
        for (int p = 0; p < n_passes; p++) begin
            gap_cycles[p]  = $unsigned($random(seed)) % 64;
            corrupt[p]     = ($random(seed) & 1) != 0;
            bad_word[p]    = $unsigned($random(seed)) % N_WORDS;
            bad_bit[p]     = $unsigned($random(seed)) % 16;
            extra_press[p] = ($random(seed) & 1) != 0;
            timeout_cycles += INIT_CYCLES + N_WORDS * 40 + 200 + gap_cycles[p]
                              + 2 * PRESS_CYCLES + SETTLE_CYCLES;
        end
        stim_ready = 1'b1;

        repeat (2) @(negedge clk_50m);
        arst_n = 1'b1;

        for (int p = 0; p < n_passes; p++) begin
            repeat (gap_cycles[p]) @(negedge clk_50m);
            refs_before = sdram_model_i.refresh_count;
            press_button();
            wait_led0(1'b0);
            // Writes are finished once the read phase begins
            while (top_traffic_gen_i.traffic_gen_i.rd_phase !== 1'b1) @(negedge clk_50m);
            if (corrupt[p]) begin
                sdram_model_i.flip_bit(bad_word[p], bad_bit[p]);
            end
            if (extra_press[p]) begin
                press_button();
            end
            wait_led0(1'b1);
            check_pass(p, refs_before);
            // A second press must not restart the pass
            repeat (SETTLE_CYCLES) @(negedge clk_50m);
            check_value("led", {corrupt[p], 1'b1}, led);
        end

        check_value("done_rises", n_passes, done_rises);
        if (top_traffic_gen_i.sdram_cmd_fsm_i.fsm_chk_i.fail_count == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("Bound assertions failed %0d times",
                     top_traffic_gen_i.sdram_cmd_fsm_i.fsm_chk_i.fail_count);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Assertion failures");
        end
    end

    // Watchdog
    initial begin
        wait (stim_ready);
        repeat (timeout_cycles) @(posedge clk_50m);
        $display("Run timed out after %0d cycles before all passes finished",
                 timeout_cycles);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Timeout");
    end

endmodule

`default_nettype wire

// File: vlog.f
rtl/sdram_pkg.sv
rtl/sdram_timer.sv
rtl/sdram_cmd_fsm.sv
rtl/sdram_datapath.sv
rtl/traffic_gen.sv
rtl/top_traffic_gen.sv
test/sdram_model.sv
test/tb_top_chk.sv
test/tb_top.sv

// File: Bender.yml
package:
  name: sdram_traffic_gen

sources:
  - rtl/sdram_pkg.sv
  - rtl/sdram_timer.sv
  - rtl/sdram_cmd_fsm.sv
  - rtl/sdram_datapath.sv
  - rtl/traffic_gen.sv
  - rtl/top_traffic_gen.sv
  - target: test
    files:
      - test/sdram_model.sv
      - test/tb_top_chk.sv
      - test/tb_top.sv
